//--- common/stripe_pkg.sv
`default_nettype none

package stripe_pkg;

  // read port and preload port widths
  localparam int ADDR_W = 10;
  localparam int DATA_W = 32;
  localparam int ID_W = 4;
  localparam int LEN_W = 8;

  // address split into {row, bank, offset}
  localparam int NUM_BANKS = 2;
  localparam int BANK_W = 1;
  localparam int OFS_W = 2;
  localparam int BANK_AW = ADDR_W - BANK_W;
  localparam int ROW_W = ADDR_W - BANK_W - OFS_W;

  // order fifo depth is 2**ORD_AW, so 4 bursts in flight
  localparam int ORD_AW = 2;

  // skid buffer payloads in stripe_rd
  localparam int AR_BITS = ID_W + ADDR_W + LEN_W;
  localparam int R_BITS = ID_W + DATA_W + 1;

  typedef union packed {
    logic [ADDR_W-1:0] flat;
    struct packed {
      logic [ROW_W-1:0]  row;
      logic [BANK_W-1:0] bank;
      logic [OFS_W-1:0]  ofs;
    } fields;
  } stripe_addr_u;

endpackage

`default_nettype wire

//--- common/axi_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

interface axi_rd_if;
  import stripe_pkg::*;

  // AR channel, address is local to the bank
  logic               arvalid;
  logic               arready;
  logic [ID_W-1:0]    arid;
  logic [BANK_AW-1:0] araddr;
  logic [LEN_W-1:0]   arlen;

  // R channel
  logic               rvalid;
  logic               rready;
  logic [ID_W-1:0]    rid;
  logic [DATA_W-1:0]  rdata;
  logic               rlast;

  modport manager (
    output arvalid, arid, araddr, arlen, rready,
    input  arready, rvalid, rid, rdata, rlast
  );

  modport subordinate (
    input  arvalid, arid, araddr, arlen, rready,
    output arready, rvalid, rid, rdata, rlast
  );

endinterface

`default_nettype wire

//--- verilog/skid_buf.sv
`timescale 1ns/1ps
`default_nettype none

module skid_buf #(
  parameter int DATA_BITS = 8,
  parameter bit OUT_REG = 1'b0
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  i_valid,
  input  wire  [DATA_BITS-1:0] i_data,
  output logic                 o_ready,
  output logic                 o_valid,
  output logic [DATA_BITS-1:0] o_data,
  input  wire                  i_ready
);

  logic                 spare_valid;
  logic [DATA_BITS-1:0] spare_data;

  // spare entry catches the beat that arrives while the output stalls
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      spare_valid <= 1'b0;
    end else if (i_valid && o_ready && o_valid && !i_ready) begin
      spare_valid <= 1'b1;
    end else if (i_ready) begin
      spare_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (o_ready) begin
      spare_data <= i_data;
    end
  end

  assign o_ready = !spare_valid;

  if (OUT_REG) begin : g_out_reg
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        o_valid <= 1'b0;
      end else if (!o_valid || i_ready) begin
        o_valid <= i_valid || spare_valid;
      end
    end

    always_ff @(posedge clk) begin
      if (!o_valid || i_ready) begin
        o_data <= spare_valid ? spare_data : i_data;
      end
    end
  end else begin : g_out_comb
    assign o_valid = i_valid || spare_valid;
    assign o_data  = spare_valid ? spare_data : i_data;
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

`default_nettype wire

//--- verilog/idx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module idx_fifo (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             i_push,
  input  wire  [2*stripe_pkg::BANK_W-1:0] i_push_bank,
  output logic                            o_full,
  input  wire                             i_pop,
  output logic [2*stripe_pkg::BANK_W-1:0] o_head_bank,
  output logic                            o_empty
);
  import stripe_pkg::*;

  // each entry is {end bank, start bank} of one burst
  logic [2*BANK_W-1:0] mem [2**ORD_AW];

  // extra pointer bit tells full from empty
  logic [ORD_AW:0] wr_ptr;
  logic [ORD_AW:0] rd_ptr;
  logic [ORD_AW:0] count;

  assign count       = wr_ptr - rd_ptr;
  assign o_full      = count[ORD_AW];
  assign o_empty     = (count == '0);
  assign o_head_bank = mem[rd_ptr[ORD_AW-1:0]];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr[ORD_AW-1:0]] <= i_push_bank;
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) i_push |-> !o_full);
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) i_pop |-> !o_empty);

endmodule

`default_nettype wire

//--- verilog/stripe_mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

module stripe_mem_bank #(
  parameter int BANK_ID = 0
) (
  input wire                           clk,
  input wire                           rst_n,
  axi_rd_if.subordinate                s_bank,
  input wire                           i_wr_en,
  input wire stripe_pkg::stripe_addr_u i_wr_addr,
  input wire [stripe_pkg::DATA_W-1:0]  i_wr_data
);
  import stripe_pkg::*;

  logic [DATA_W-1:0] mem [2**ROW_W];

  logic              rvalid_q;
  logic              rlast_q;
  logic [ID_W-1:0]   rid_q;
  logic [DATA_W-1:0] rdata_q;
  logic [ROW_W-1:0]  next_row;
  logic [LEN_W-1:0]  beats_left;
  logic [ROW_W-1:0]  ar_row;
  logic              ar_take;
  logic              r_take;

  // preload, only words striped onto this bank
  always_ff @(posedge clk) begin
    if (i_wr_en && i_wr_addr.fields.bank == BANK_W'(BANK_ID)) begin
      mem[i_wr_addr.fields.row] <= i_wr_data;
    end
  end

  // byte offset of the local address is ignored, beats are full words
  assign ar_row  = s_bank.araddr[BANK_AW-1:OFS_W];
  assign ar_take = s_bank.arvalid && !rvalid_q;
  assign r_take  = rvalid_q && s_bank.rready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rvalid_q <= 1'b0;
    end else if (ar_take) begin
      rvalid_q <= 1'b1;
    end else if (r_take && rlast_q) begin
      rvalid_q <= 1'b0;
    end
  end

  // burst streams consecutive rows, one per beat
  always_ff @(posedge clk) begin
    if (ar_take) begin
      rid_q      <= s_bank.arid;
      rdata_q    <= mem[ar_row];
      next_row   <= ar_row + 1'b1;
      beats_left <= s_bank.arlen;
      rlast_q    <= (s_bank.arlen == '0);
    end else if (r_take && !rlast_q) begin
      rdata_q    <= mem[next_row];
      next_row   <= next_row + 1'b1;
      beats_left <= beats_left - 1'b1;
      rlast_q    <= (beats_left == LEN_W'(1));
    end
  end

  assign s_bank.arready = !rvalid_q;
  assign s_bank.rvalid  = rvalid_q;
  assign s_bank.rid     = rid_q;
  assign s_bank.rdata   = rdata_q;
  assign s_bank.rlast   = rlast_q;

endmodule

`default_nettype wire

//--- stripe_rd/stripe_rd.sv
`timescale 1ns/1ps
`default_nettype none

module stripe_rd (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           i_arvalid,
  input  wire   [stripe_pkg::ID_W-1:0]   i_arid,
  input  wire   [stripe_pkg::ADDR_W-1:0] i_araddr,
  input  wire   [stripe_pkg::LEN_W-1:0]  i_arlen,
  output logic                          o_arready,
  output logic                          o_rvalid,
  output logic  [stripe_pkg::ID_W-1:0]   o_rid,
  output logic  [stripe_pkg::DATA_W-1:0] o_rdata,
  output logic                          o_rlast,
  input  wire                           i_rready,
  axi_rd_if.manager                     m_bank0,
  axi_rd_if.manager                     m_bank1
);
  import stripe_pkg::*;

  logic                 sb_arvalid;
  logic                 sb_arready;
  logic [ID_W-1:0]      sb_arid;
  stripe_addr_u         sb_araddr;
  logic [LEN_W-1:0]     sb_arlen;
  logic                 ar_take;
  logic [BANK_W-1:0]    ar_start;
  logic [BANK_W-1:0]    ar_end;

  logic [NUM_BANKS-1:0] split_valid;
  logic [BANK_AW-1:0]   split_addr [NUM_BANKS];
  logic [LEN_W-1:0]     split_len [NUM_BANKS];

  logic [NUM_BANKS-1:0] bank_arvalid;
  logic [NUM_BANKS-1:0] bank_arready;
  logic [ID_W-1:0]      bank_arid;
  logic [BANK_AW-1:0]   bank_araddr [NUM_BANKS];
  logic [LEN_W-1:0]     bank_arlen [NUM_BANKS];

  logic                 fifo_full;
  logic                 fifo_empty;
  logic [BANK_W-1:0]    r_start;
  logic [BANK_W-1:0]    r_end;
  logic [BANK_W-1:0]    r_ofs;
  logic [BANK_W-1:0]    r_idx;

  logic [NUM_BANKS-1:0] br_valid;
  logic [NUM_BANKS-1:0] br_ready;
  logic [R_BITS-1:0]    br_data [NUM_BANKS];
  logic [NUM_BANKS-1:0] sb_rvalid;
  logic [NUM_BANKS-1:0] sb_rready;
  logic [R_BITS-1:0]    sb_rdata [NUM_BANKS];

  logic                 mux_valid;
  logic                 mux_ready;
  logic                 mux_last;
  logic                 mux_take;
  logic [R_BITS-1:0]    mux_word;

  // ----------------------------------------
  // AR path
  // ----------------------------------------
  skid_buf #(.DATA_BITS(AR_BITS), .OUT_REG(1'b0)) ar_sb_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(i_arvalid),
    .i_data ({i_arid, i_araddr, i_arlen}),
    .o_ready(o_arready),
    .o_valid(sb_arvalid),
    .o_data ({sb_arid, sb_araddr.flat, sb_arlen}),
    .i_ready(sb_arready)
  );

  // every bank slot must be free or draining this cycle
  assign sb_arready = !fifo_full && &(~bank_arvalid | bank_arready);
  assign ar_take    = sb_arvalid && sb_arready;
  assign ar_start   = sb_araddr.fields.bank;
  assign ar_end     = ar_start + sb_arlen[BANK_W-1:0];

  // start bank takes the even beats, the other bank the odd ones
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (BANK_W'(b) == ar_start) begin
        split_valid[b] = 1'b1;
        split_len[b]   = sb_arlen >> 1;
      end else begin
        split_valid[b] = (sb_arlen != '0);
        split_len[b]   = (sb_arlen - 1'b1) >> 1;
      end
      // a bank below the start bank begins one row later
      split_addr[b] = {sb_araddr.fields.row + ROW_W'(BANK_W'(b) < ar_start),
                       sb_araddr.fields.ofs};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bank_arvalid <= '0;
    end else if (ar_take) begin
      bank_arvalid <= split_valid;
    end else begin
      bank_arvalid <= bank_arvalid & ~bank_arready;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_take) begin
      bank_arid <= sb_arid;
      for (int b = 0; b < NUM_BANKS; b++) begin
        bank_araddr[b] <= split_addr[b];
        bank_arlen[b]  <= split_len[b];
      end
    end
  end

  assign m_bank0.arvalid = bank_arvalid[0];
  assign m_bank0.arid    = bank_arid;
  assign m_bank0.araddr  = bank_araddr[0];
  assign m_bank0.arlen   = bank_arlen[0];
  assign m_bank1.arvalid = bank_arvalid[1];
  assign m_bank1.arid    = bank_arid;
  assign m_bank1.araddr  = bank_araddr[1];
  assign m_bank1.arlen   = bank_arlen[1];
  assign bank_arready    = {m_bank1.arready, m_bank0.arready};

  // burst order for the merge
  idx_fifo ord_fifo_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_push     (ar_take),
    .i_push_bank({ar_end, ar_start}),
    .o_full     (fifo_full),
    .i_pop      (mux_take && mux_last),
    .o_head_bank({r_end, r_start}),
    .o_empty    (fifo_empty)
  );

  // ----------------------------------------
  // R path
  // ----------------------------------------
  assign br_valid       = {m_bank1.rvalid, m_bank0.rvalid};
  assign br_data[0]     = {m_bank0.rid, m_bank0.rdata, m_bank0.rlast};
  assign br_data[1]     = {m_bank1.rid, m_bank1.rdata, m_bank1.rlast};
  assign m_bank0.rready = br_ready[0];
  assign m_bank1.rready = br_ready[1];

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank_r
    skid_buf #(.DATA_BITS(R_BITS), .OUT_REG(1'b1)) r_sb_i (
      .clk    (clk),
      .rst_n  (rst_n),
      .i_valid(br_valid[b]),
      .i_data (br_data[b]),
      .o_ready(br_ready[b]),
      .o_valid(sb_rvalid[b]),
      .o_data (sb_rdata[b]),
      .i_ready(sb_rready[b])
    );
  end

  // walk the banks alternately from the start bank of the head burst
  assign r_idx = r_start + r_ofs;

  always_comb begin
    mux_valid = 1'b0;
    mux_word  = '0;
    sb_rready = '0;
    if (!fifo_empty) begin
      mux_valid        = sb_rvalid[r_idx];
      mux_word         = sb_rdata[r_idx];
      sb_rready[r_idx] = mux_ready;
    end
  end

  // bank rlast only counts on the bank that ends the burst
  assign mux_last = mux_word[0] && (r_idx == r_end);
  assign mux_take = mux_valid && mux_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_ofs <= '0;
    end else if (mux_take) begin
      r_ofs <= mux_last ? '0 : r_ofs + 1'b1;
    end
  end

  skid_buf #(.DATA_BITS(R_BITS), .OUT_REG(1'b1)) out_sb_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .i_valid(mux_valid),
    .i_data ({mux_word[R_BITS-1:1], mux_last}),
    .o_ready(mux_ready),
    .o_valid(o_rvalid),
    .o_data ({o_rid, o_rdata, o_rlast}),
    .i_ready(i_rready)
  );

  // a bank only returns data for a burst that is still tracked
  a_rvalid_tracked: assert property (@(posedge clk) disable iff (!rst_n)
    (m_bank0.rvalid || m_bank1.rvalid) |-> !fifo_empty);

endmodule

`default_nettype wire

//--- verilog/stripe_top.sv
`timescale 1ns/1ps
`default_nettype none

module stripe_top (
  input  wire                           clk,
  input  wire                           rst_n,

  // read port
  input  wire                           i_arvalid,
  input  wire   [stripe_pkg::ID_W-1:0]   i_arid,
  input  wire   [stripe_pkg::ADDR_W-1:0] i_araddr,
  input  wire   [stripe_pkg::LEN_W-1:0]  i_arlen,
  output logic                          o_arready,
  output logic                          o_rvalid,
  output logic  [stripe_pkg::ID_W-1:0]   o_rid,
  output logic  [stripe_pkg::DATA_W-1:0] o_rdata,
  output logic                          o_rlast,
  input  wire                           i_rready,

  // preload port
  input  wire                           i_wr_en,
  input  wire   [stripe_pkg::ADDR_W-1:0] i_wr_addr,
  input  wire   [stripe_pkg::DATA_W-1:0] i_wr_data
);

  axi_rd_if bank0_if ();
  axi_rd_if bank1_if ();

  stripe_mem_bank #(.BANK_ID(0)) bank0_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .s_bank   (bank0_if.subordinate),
    .i_wr_en  (i_wr_en),
    .i_wr_addr(i_wr_addr),
    .i_wr_data(i_wr_data)
  );

  stripe_mem_bank #(.BANK_ID(1)) bank1_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .s_bank   (bank1_if.subordinate),
    .i_wr_en  (i_wr_en),
    .i_wr_addr(i_wr_addr),
    .i_wr_data(i_wr_data)
  );

  stripe_rd stripe_rd_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_arvalid(i_arvalid),
    .i_arid   (i_arid),
    .i_araddr (i_araddr),
    .i_arlen  (i_arlen),
    .o_arready(o_arready),
    .o_rvalid (o_rvalid),
    .o_rid    (o_rid),
    .o_rdata  (o_rdata),
    .o_rlast  (o_rlast),
    .i_rready (i_rready),
    .m_bank0  (bank0_if.manager),
    .m_bank1  (bank1_if.manager)
  );

endmodule

`default_nettype wire

//--- test/tb_clk.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk (
  output logic o_clk,
  output logic o_rst_n
);

  localparam int HALF_PERIOD = 2;
  localparam int RESET_CYCLES = 8;

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // release on a falling edge, like the rest of the stimulus
  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- test/stripe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module stripe_tb;
  import stripe_pkg::*;

  // preload plus roughly 30 bursts of up to 16 beats at half-rate rready, with wide margin
  localparam int TIMEOUT_CYCLES = 20000;
  localparam int WORDS = 2**(ADDR_W - OFS_W);

  logic              clk;
  logic              rst_n;
  logic              i_arvalid;
  logic [ID_W-1:0]   i_arid;
  logic [ADDR_W-1:0] i_araddr;
  logic [LEN_W-1:0]  i_arlen;
  logic              o_arready;
  logic              o_rvalid;
  logic [ID_W-1:0]   o_rid;
  logic [DATA_W-1:0] o_rdata;
  logic              o_rlast;
  logic              i_rready = 1'b1;
  logic              i_wr_en;
  logic [ADDR_W-1:0] i_wr_addr;
  logic [DATA_W-1:0] i_wr_data;

  logic [DATA_W-1:0] shadow [WORDS];
  logic [31:0]       rng = 32'h33db;
  logic [31:0]       rdy_rng = 32'h33db;
  logic              rready_random = 1'b0;
  int                cycle_count = 0;

  // circular buffer of expected beats with its head at exp_rd
  logic [DATA_W-1:0] exp_data [256];
  logic [ID_W-1:0]   exp_id [256];
  logic              exp_last [256];
  logic [7:0]        exp_wr;
  logic [7:0]        exp_rd;

  tb_clk tb_clk_i (
    .o_clk  (clk),
    .o_rst_n(rst_n)
  );

  stripe_top stripe_top_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_arvalid(i_arvalid),
    .i_arid   (i_arid),
    .i_araddr (i_araddr),
    .i_arlen  (i_arlen),
    .o_arready(o_arready),
    .o_rvalid (o_rvalid),
    .o_rid    (o_rid),
    .o_rdata  (o_rdata),
    .o_rlast  (o_rlast),
    .i_rready (i_rready),
    .i_wr_en  (i_wr_en),
    .i_wr_addr(i_wr_addr),
    .i_wr_data(i_wr_data)
  );

  function automatic logic [31:0] lcg(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Verification failed");
    $fatal(1);
  endtask

  // ----------------------------------------
  // scoreboard and checks
  // ----------------------------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_wr <= '0;
      exp_rd <= '0;
    end else begin
      if (i_arvalid && o_arready) begin
        for (int k = 0; k <= int'(i_arlen); k++) begin
          exp_data[8'(exp_wr + k)] <= shadow[8'(i_araddr[ADDR_W-1:OFS_W] + k)];
          exp_id[8'(exp_wr + k)]   <= i_arid;
          exp_last[8'(exp_wr + k)] <= (k == int'(i_arlen));
        end
        exp_wr <= 8'(exp_wr + int'(i_arlen) + 1);
      end
      if (o_rvalid && i_rready) begin
        exp_rd <= exp_rd + 8'd1;
      end
    end
  end

  a_reset_idle: assert property (@(posedge clk) !rst_n |=> !o_rvalid)
    else abort_run($sformatf("[FAIL] t=%0t: o_rvalid high during reset", $time));
  a_ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> o_arready && !o_rvalid)
    else abort_run($sformatf("[FAIL] t=%0t: port not idle and ready after reset", $time));
  a_beat_expected: assert property (@(posedge clk) disable iff (!rst_n)
    o_rvalid && i_rready |-> exp_wr != exp_rd)
    else abort_run($sformatf("[FAIL] t=%0t: beat returned with none expected", $time));
  a_beat_data: assert property (@(posedge clk) disable iff (!rst_n)
    o_rvalid && i_rready |-> o_rdata == exp_data[exp_rd])
    else abort_run($sformatf("[FAIL] t=%0t: rdata %h, expected %h", $time, o_rdata,
                             exp_data[exp_rd]));
  a_beat_id: assert property (@(posedge clk) disable iff (!rst_n)
    o_rvalid && i_rready |-> o_rid == exp_id[exp_rd])
    else abort_run($sformatf("[FAIL] t=%0t: rid %h, expected %h", $time, o_rid,
                             exp_id[exp_rd]));
  a_beat_last: assert property (@(posedge clk) disable iff (!rst_n)
    o_rvalid && i_rready |-> o_rlast == exp_last[exp_rd])
    else abort_run($sformatf("[FAIL] t=%0t: rlast %b, expected %b", $time, o_rlast,
                             exp_last[exp_rd]));
  a_beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
    o_rvalid && !i_rready |=> o_rvalid && $stable({o_rid, o_rdata, o_rlast}))
    else abort_run($sformatf("[FAIL] t=%0t: R beat changed while stalled", $time));

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      abort_run("timeout: the test did not finish within the cycle limit");
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  always @(negedge clk) begin
    if (rready_random) begin
      rdy_rng = lcg(rdy_rng);
      i_rready <= rdy_rng[31];
    end else begin
      i_rready <= 1'b1;
    end
  end

  // called on a falling edge, returns on the falling edge after the AR transfer
  task automatic send_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                            input logic [LEN_W-1:0] len);
    logic taken;
    i_arvalid = 1'b1;
    i_arid    = id;
    i_araddr  = addr;
    i_arlen   = len;
    taken     = 1'b0;
    while (!taken) begin
      // o_arready is registered so it holds until the next rising edge
      taken = o_arready;
      @(negedge clk);
    end
  endtask

  task automatic send_random_burst(input logic [ID_W-1:0] id, input logic [LEN_W-1:0] len_mask);
    logic [7:0]       word;
    logic [LEN_W-1:0] len;
    rng  = lcg(rng);
    len  = rng[31:24] & len_mask;
    word = rng[23:16];
    // keep the burst inside the memory
    if (word > 8'd240) begin
      word = word - 8'd16;
    end
    send_burst(id, {word, 2'b00}, len);
  endtask

  task automatic wait_drain();
    i_arvalid = 1'b0;
    while (exp_wr != exp_rd) begin
      @(negedge clk);
    end
  endtask

  initial begin
    i_arvalid = 1'b0;
    i_arid    = '0;
    i_araddr  = '0;
    i_arlen   = '0;
    i_wr_en   = 1'b0;
    i_wr_addr = '0;
    i_wr_data = '0;
    wait (rst_n === 1'b1);
    @(negedge clk);

    for (int w = 0; w < WORDS; w++) begin
      rng       = lcg(rng);
      i_wr_en   = 1'b1;
      i_wr_addr = ADDR_W'(w << OFS_W);
      i_wr_data = rng;
      shadow[w] = rng;
      @(negedge clk);
    end
    i_wr_en = 1'b0;

    // a single beat from each bank
    send_burst(4'd1, 10'h040, 8'd0);
    send_burst(4'd2, 10'h044, 8'd0);
    wait_drain();

    // even length from bank 0
    send_burst(4'd3, 10'h100, 8'd7);
    wait_drain();

    // odd lengths from bank 1 where three beats leave bank 0 one beat
    send_burst(4'd4, 10'h204, 8'd4);
    send_burst(4'd5, 10'h30c, 8'd2);
    // the last burst steps into the next row of bank 0
    send_burst(4'd6, 10'h0fc, 8'd1);
    wait_drain();

    // four outstanding
    for (int n = 0; n < 4; n++) begin
      send_random_burst(ID_W'(8 + n), 8'h07);
    end
    wait_drain();

    rready_random <= 1'b1;
    for (int n = 0; n < 24; n++) begin
      send_random_burst(ID_W'(n), 8'h0f);
    end
    wait_drain();
    rready_random <= 1'b0;

    // idle window so a stray beat still hits the checks
    repeat (16) @(negedge clk);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
common/stripe_pkg.sv
common/axi_rd_if.sv
verilog/skid_buf.sv
verilog/idx_fifo.sv
verilog/stripe_mem_bank.sv
stripe_rd/stripe_rd.sv
verilog/stripe_top.sv
test/tb_clk.sv
test/stripe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module stripe_tb -f verilog.f -o stripe_sim

# the simulator exits nonzero on a failed check, keep its output for the search
sim_out="$(./obj_dir/stripe_sim 2>&1)" || true
echo "$sim_out"

if grep -qx "Verification passed" <<< "$sim_out"; then
  exit 0
fi
exit 1
